// File: source/tile_pkg.sv
// Compute tile bus definitions
package tile_pkg;

   localparam int DATA_WIDTH = 32;
   localparam int ADDR_WIDTH = 32;
   localparam int SEL_WIDTH  = 4;                 // One bit per byte lane

   // Region tags in the top address nibble
   localparam logic [3:0] NA_MATCH  = 4'hE;       // Network adapter
   localparam logic [3:0] ROM_MATCH = 4'hF;       // Boot ROM

   localparam int NUM_SLAVES = 3;

   typedef enum logic [1:0] {
      SLV_MEM = 2'd0,                             // Local SRAM, adr[31] == 0
      SLV_NA  = 2'd1,
      SLV_ROM = 2'd2
   } slave_idx_e;

   // Adapter register offsets
   localparam logic [3:0] NA_REG_SEND = 4'h0;     // Write sends a flit, read gives rx count
   localparam logic [3:0] NA_REG_RECV = 4'h4;     // Read pops one received word

   // Boot code, word indexed by address bits 4:2
   localparam logic [DATA_WIDTH-1:0] BOOT_ROM [0:7] = '{
      32'h1800_0000,                              // l.movhi r0,0
      32'hA820_0000,                              // l.ori r1,r0,0
      32'h1860_E000,                              // l.movhi r3,0xe000
      32'h8483_0000,                              // l.lwz r4,0(r3)
      32'hBC04_0000,                              // l.sfeqi r4,0
      32'h13FF_FFFE,                              // l.bf -2
      32'h1500_0000,                              // l.nop
      32'h0000_0000                               // l.j 0
   };

endpackage

// File: source/noc_pkg.sv
// NoC flit and header layout
package noc_pkg;

   // Flit is {first, last, payload}
   localparam int FLIT_WIDTH    = 34;
   localparam int TILE_ID_WIDTH = 5;

   localparam int FLIT_FIRST_BIT = FLIT_WIDTH - 1;
   localparam int FLIT_LAST_BIT  = FLIT_WIDTH - 2;

   // The same payload word seen as plain data or as a packet header.
   // The header occupies the payload of the first flit of every packet.
   typedef union packed {
      logic [31:0] raw;                           // Data flit view
      struct packed {
         logic [TILE_ID_WIDTH-1:0] dest;          // Destination tile
         logic [2:0]               pclass;        // Message class
         logic [TILE_ID_WIDTH-1:0] src;           // Sending tile
         logic [10:0]              rsvd;
         logic [7:0]               len;           // Data flits after the header
      } hdr;
   } noc_hdr_u;

endpackage

// File: source/wb_bus_decode.sv
// Wishbone address decoder
`timescale 1ns/1ps

module wb_bus_decode (
   input  logic                                             clk_i,
   input  logic                                             arst_n_i,
   input  logic                                             cyc_i,
   input  logic                                             stb_i,
   input  logic [tile_pkg::ADDR_WIDTH-1:0]                  adr_i,
   output logic                                             ack_o,
   output logic                                             err_o,
   output logic [tile_pkg::DATA_WIDTH-1:0]                  dat_o,
   output logic [tile_pkg::NUM_SLAVES-1:0]                  slv_cyc_o,
   output logic [tile_pkg::NUM_SLAVES-1:0]                  slv_stb_o,
   input  logic [tile_pkg::NUM_SLAVES-1:0]                  slv_ack_i,
   input  logic [tile_pkg::NUM_SLAVES-1:0][tile_pkg::DATA_WIDTH-1:0] slv_dat_i
);

   tile_pkg::slave_idx_e sel_idx;
   logic                 mapped;
   logic                 err_q;

   always_comb begin
      sel_idx = tile_pkg::SLV_MEM;
      mapped  = 1'b1;
      if (!adr_i[31]) begin
         sel_idx = tile_pkg::SLV_MEM;             // Lower half is local SRAM
      end else if (adr_i[31:28] == tile_pkg::NA_MATCH) begin
         sel_idx = tile_pkg::SLV_NA;
      end else if (adr_i[31:28] == tile_pkg::ROM_MATCH) begin
         sel_idx = tile_pkg::SLV_ROM;
      end else begin
         mapped = 1'b0;                           // 0x8 to 0xD go nowhere
      end
   end

   always_comb begin
      for (int i = 0; i < tile_pkg::NUM_SLAVES; i++) begin
         slv_cyc_o[i] = cyc_i && mapped && (int'(sel_idx) == i);
         slv_stb_o[i] = stb_i && mapped && (int'(sel_idx) == i);
      end
   end

   // Error pulse for unmapped accesses, one cycle after the request
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= cyc_i && stb_i && !mapped && !err_q;
      end
   end

   assign ack_o = mapped && slv_ack_i[sel_idx];
   assign err_o = err_q;
   assign dat_o = mapped ? slv_dat_i[sel_idx] : '0;

   // No slave may ack while a decode error goes back to the master
   a_ack_err_excl : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !(err_o && (|slv_ack_i)));

endmodule

// File: source/wb_sram_sp.sv
// Local single-port SRAM
`timescale 1ns/1ps

module wb_sram_sp #(
   parameter int MEM_WORDS = 256
) (
   input  logic                           clk_i,
   input  logic                           arst_n_i,
   input  logic                           stb_i,
   input  logic                           cyc_i,
   input  logic                           we_i,
   input  logic [tile_pkg::ADDR_WIDTH-1:0] adr_i,
   input  logic [tile_pkg::DATA_WIDTH-1:0] dat_i,
   input  logic [tile_pkg::SEL_WIDTH-1:0]  sel_i,
   output logic                           ack_o,
   output logic [tile_pkg::DATA_WIDTH-1:0] dat_o
);

   localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

   logic [tile_pkg::DATA_WIDTH-1:0] mem [MEM_WORDS];
   logic [tile_pkg::DATA_WIDTH-1:0] rdata_q;
   logic [IDX_W-1:0]                word_idx;
   logic                            req;
   logic                            ack_q;

   assign req      = stb_i && cyc_i && !ack_q;   // New access, not yet acked
   assign word_idx = IDX_W'(adr_i[tile_pkg::ADDR_WIDTH-1:2] % MEM_WORDS);

   always_ff @(posedge clk_i) begin
      if (req && we_i) begin
         for (int b = 0; b < tile_pkg::SEL_WIDTH; b++) begin
            if (sel_i[b]) begin
               mem[word_idx][8*b +: 8] <= dat_i[8*b +: 8];
            end
         end
      end
      if (req) begin
         rdata_q <= mem[word_idx];               // Old word on a write, unused
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= req;
      end
   end

   assign ack_o = ack_q;
   assign dat_o = rdata_q;

   a_ack_has_req : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      ack_o |-> $past(stb_i && cyc_i));

endmodule

// File: source/bootrom.sv
// Boot code ROM
`timescale 1ns/1ps

module bootrom (
   input  logic                           clk_i,
   input  logic                           arst_n_i,
   input  logic                           stb_i,
   input  logic                           cyc_i,
   input  logic [tile_pkg::ADDR_WIDTH-1:0] adr_i,
   output logic                           ack_o,
   output logic [tile_pkg::DATA_WIDTH-1:0] dat_o
);

   logic                            req;
   logic                            ack_q;
   logic [tile_pkg::DATA_WIDTH-1:0] rom_q;

   assign req = stb_i && cyc_i && !ack_q;

   // Writes take the same path and simply never reach the table
   always_ff @(posedge clk_i) begin
      if (req) begin
         rom_q <= tile_pkg::BOOT_ROM[adr_i[4:2]];
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= req;                           // Fixed one-cycle latency
      end
   end

   assign ack_o = ack_q;
   assign dat_o = rom_q;

endmodule

// File: source/na_mp_simple.sv
// Message-passing network adapter
`timescale 1ns/1ps

module na_mp_simple #(
   parameter logic [noc_pkg::TILE_ID_WIDTH-1:0] TILE_ID  = '0,
   parameter int                                RX_DEPTH = 16
) (
   input  logic                            clk_i,
   input  logic                            arst_n_i,
   input  logic                            stb_i,
   input  logic                            cyc_i,
   input  logic                            we_i,
   input  logic [tile_pkg::ADDR_WIDTH-1:0] adr_i,
   input  logic [tile_pkg::DATA_WIDTH-1:0] dat_i,
   output logic                            ack_o,
   output logic [tile_pkg::DATA_WIDTH-1:0] dat_o,
   input  logic [noc_pkg::FLIT_WIDTH-1:0]  noc_in_flit_i,
   input  logic                            noc_in_valid_i,
   output logic                            noc_in_ready_o,
   output logic [noc_pkg::FLIT_WIDTH-1:0]  noc_out_flit_o,
   output logic                            noc_out_valid_o,
   input  logic                            noc_out_ready_i,
   output logic                            irq_o
);

   localparam int PTR_W = (RX_DEPTH > 1) ? $clog2(RX_DEPTH) : 1;
   localparam int CNT_W = $clog2(RX_DEPTH + 1);

   logic                            req, take, send_take, send_ok;
   logic                            is_send, is_recv;
   logic                            ack_q;
   logic [tile_pkg::DATA_WIDTH-1:0] rdata_q;
   logic [tile_pkg::DATA_WIDTH-1:0] count_word;

   noc_pkg::noc_hdr_u               tx_hdr;
   logic                            tx_first, tx_last;
   logic [7:0]                      remain_q;
   logic [noc_pkg::FLIT_WIDTH-1:0]  out_flit_q;
   logic                            out_valid_q;

   noc_pkg::noc_hdr_u               rx_hdr;
   logic                            rx_accept, rx_first, rx_last;
   logic                            rx_foreign, rx_drop, drop_q;
   logic                            rx_push, rx_pop, rx_full, rx_empty;
   logic [tile_pkg::DATA_WIDTH-1:0] rx_mem [RX_DEPTH];
   logic [PTR_W-1:0]                wr_ptr_q, rd_ptr_q;
   logic [CNT_W-1:0]                rx_count_q;

   // Register access
   assign req       = stb_i && cyc_i && !ack_q;
   assign is_send   = adr_i[3:0] == tile_pkg::NA_REG_SEND;
   assign is_recv   = adr_i[3:0] == tile_pkg::NA_REG_RECV;
   assign send_ok   = !out_valid_q || noc_out_ready_i;    // Output slot free this cycle
   assign take      = req && (!(we_i && is_send) || send_ok);
   assign send_take = take && we_i && is_send;
   assign count_word = {{(tile_pkg::DATA_WIDTH - CNT_W){1'b0}}, rx_count_q};

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= take;                          // Held back while the flit slot is busy
      end
   end

   always_ff @(posedge clk_i) begin
      if (take && !we_i) begin
         if (is_send) begin
            rdata_q <= count_word;
         end else if (is_recv && !rx_empty) begin
            rdata_q <= rx_mem[rd_ptr_q];
         end else begin
            rdata_q <= '0;                       // Empty FIFO or unused offset
         end
      end
   end

   // Send path, header when no data flits are outstanding
   assign tx_hdr.raw = dat_i;
   assign tx_first   = remain_q == 8'd0;
   assign tx_last    = tx_first ? (tx_hdr.hdr.len == 8'd0) : (remain_q == 8'd1);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         out_valid_q <= 1'b0;
         remain_q    <= 8'd0;
      end else if (send_take) begin
         out_valid_q <= 1'b1;
         if (tx_first) begin
            remain_q <= tx_hdr.hdr.len;
         end else begin
            remain_q <= remain_q - 8'd1;
         end
      end else if (noc_out_ready_i) begin
         out_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (send_take) begin
         out_flit_q <= {tx_first, tx_last, dat_i};
      end
   end

   // Receive path
   assign rx_full    = rx_count_q == CNT_W'(RX_DEPTH);
   assign rx_empty   = rx_count_q == '0;
   assign rx_accept  = noc_in_valid_i && !rx_full;
   assign rx_first   = noc_in_flit_i[noc_pkg::FLIT_FIRST_BIT];
   assign rx_last    = noc_in_flit_i[noc_pkg::FLIT_LAST_BIT];
   assign rx_hdr.raw = noc_in_flit_i[tile_pkg::DATA_WIDTH-1:0];
   assign rx_foreign = rx_hdr.hdr.dest != TILE_ID;
   assign rx_drop    = rx_first ? rx_foreign : drop_q;
   assign rx_push    = rx_accept && !rx_drop;       // Header is stored with its data
   assign rx_pop     = take && !we_i && is_recv && !rx_empty;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         drop_q <= 1'b0;
      end else if (rx_accept) begin
         if (rx_first) begin
            drop_q <= rx_foreign && !rx_last;    // Single-flit packet ends at once
         end else if (rx_last) begin
            drop_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rx_push) begin
         rx_mem[wr_ptr_q] <= rx_hdr.raw;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         rx_count_q <= '0;
      end else begin
         if (rx_push) begin
            wr_ptr_q <= (wr_ptr_q == PTR_W'(RX_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (rx_pop) begin
            rd_ptr_q <= (rd_ptr_q == PTR_W'(RX_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         case ({rx_push, rx_pop})
            2'b10:   rx_count_q <= rx_count_q + 1'b1;
            2'b01:   rx_count_q <= rx_count_q - 1'b1;
            default: rx_count_q <= rx_count_q;
         endcase
      end
   end

   assign ack_o           = ack_q;
   assign dat_o           = rdata_q;
   assign noc_out_flit_o  = out_flit_q;
   assign noc_out_valid_o = out_valid_q;
   assign noc_in_ready_o  = !rx_full;
   assign irq_o           = !rx_empty;            // Messages waiting

   a_out_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      noc_out_valid_o && !noc_out_ready_i |=> noc_out_valid_o && $stable(noc_out_flit_o));

   // A push never lands on a word that is still unread
   a_no_overflow : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      rx_push |-> rx_empty || (wr_ptr_q != rd_ptr_q));

endmodule

// File: source/compute_tile.sv
// Compute tile top level
`timescale 1ns/1ps

module compute_tile #(
   parameter logic [noc_pkg::TILE_ID_WIDTH-1:0] TILE_ID   = '0,
   parameter int                                MEM_WORDS = 256,
   parameter int                                RX_DEPTH  = 16
) (
   input  logic                            clk_i,
   input  logic                            arst_n_i,
   input  logic                            wb_cyc_i,
   input  logic                            wb_stb_i,
   input  logic                            wb_we_i,
   input  logic [tile_pkg::ADDR_WIDTH-1:0] wb_adr_i,
   input  logic [tile_pkg::DATA_WIDTH-1:0] wb_dat_i,
   input  logic [tile_pkg::SEL_WIDTH-1:0]  wb_sel_i,
   output logic                            wb_ack_o,
   output logic                            wb_err_o,
   output logic [tile_pkg::DATA_WIDTH-1:0] wb_dat_o,
   input  logic [noc_pkg::FLIT_WIDTH-1:0]  noc_in_flit_i,
   input  logic                            noc_in_valid_i,
   output logic                            noc_in_ready_o,
   output logic [noc_pkg::FLIT_WIDTH-1:0]  noc_out_flit_o,
   output logic                            noc_out_valid_o,
   input  logic                            noc_out_ready_i,
   output logic                            irq_o
);

   logic [tile_pkg::NUM_SLAVES-1:0]                          slv_cyc;
   logic [tile_pkg::NUM_SLAVES-1:0]                          slv_stb;
   logic [tile_pkg::NUM_SLAVES-1:0]                          slv_ack;
   logic [tile_pkg::NUM_SLAVES-1:0][tile_pkg::DATA_WIDTH-1:0] slv_dat;

   wb_bus_decode u_bus (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .cyc_i     (wb_cyc_i),
      .stb_i     (wb_stb_i),
      .adr_i     (wb_adr_i),
      .ack_o     (wb_ack_o),
      .err_o     (wb_err_o),
      .dat_o     (wb_dat_o),
      .slv_cyc_o (slv_cyc),
      .slv_stb_o (slv_stb),
      .slv_ack_i (slv_ack),
      .slv_dat_i (slv_dat)
   );

   // Address, write data, select and we go to every slave unchanged
   wb_sram_sp #(
      .MEM_WORDS (MEM_WORDS)
   ) u_ram (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .stb_i    (slv_stb[tile_pkg::SLV_MEM]),
      .cyc_i    (slv_cyc[tile_pkg::SLV_MEM]),
      .we_i     (wb_we_i),
      .adr_i    (wb_adr_i),
      .dat_i    (wb_dat_i),
      .sel_i    (wb_sel_i),
      .ack_o    (slv_ack[tile_pkg::SLV_MEM]),
      .dat_o    (slv_dat[tile_pkg::SLV_MEM])
   );

   na_mp_simple #(
      .TILE_ID  (TILE_ID),
      .RX_DEPTH (RX_DEPTH)
   ) u_na (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .stb_i           (slv_stb[tile_pkg::SLV_NA]),
      .cyc_i           (slv_cyc[tile_pkg::SLV_NA]),
      .we_i            (wb_we_i),
      .adr_i           (wb_adr_i),
      .dat_i           (wb_dat_i),
      .ack_o           (slv_ack[tile_pkg::SLV_NA]),
      .dat_o           (slv_dat[tile_pkg::SLV_NA]),
      .noc_in_flit_i   (noc_in_flit_i),
      .noc_in_valid_i  (noc_in_valid_i),
      .noc_in_ready_o  (noc_in_ready_o),
      .noc_out_flit_o  (noc_out_flit_o),
      .noc_out_valid_o (noc_out_valid_o),
      .noc_out_ready_i (noc_out_ready_i),
      .irq_o           (irq_o)
   );

   bootrom u_bootrom (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .stb_i    (slv_stb[tile_pkg::SLV_ROM]),
      .cyc_i    (slv_cyc[tile_pkg::SLV_ROM]),
      .adr_i    (wb_adr_i),
      .ack_o    (slv_ack[tile_pkg::SLV_ROM]),
      .dat_o    (slv_dat[tile_pkg::SLV_ROM])
   );

endmodule

// File: test/tb_compute_tile.sv
// Compute tile testbench
`timescale 1ns/1ps

module tb_compute_tile;

   localparam int CLK_PERIOD = 40;
   localparam int TILE_ID    = 3;
   localparam int MEM_WORDS  = 256;
   localparam int RX_DEPTH   = 16;
   localparam int N_INIT     = 16;                 // SRAM words under test
   localparam int N_MEM      = 40;                 // Random write and read pairs
   localparam int N_ERR      = 12;
   localparam int N_TX       = 6;
   localparam int N_RX       = 12;
   localparam int MAX_LEN    = 6;
   localparam int NUM_OPS    = N_INIT + 2 * N_MEM + 8 + N_ERR + N_TX * (MAX_LEN + 1)
                               + N_RX * (3 * MAX_LEN + 8);
   localparam int TIMEOUT_NS = NUM_OPS * 200 * CLK_PERIOD;

   localparam logic [tile_pkg::ADDR_WIDTH-1:0] NA_SEND_ADR =
      {tile_pkg::NA_MATCH, 24'd0, tile_pkg::NA_REG_SEND};
   localparam logic [tile_pkg::ADDR_WIDTH-1:0] NA_RECV_ADR =
      {tile_pkg::NA_MATCH, 24'd0, tile_pkg::NA_REG_RECV};

   logic                            clk_i;
   logic                            arst_n_i;
   logic                            wb_cyc_i;
   logic                            wb_stb_i;
   logic                            wb_we_i;
   logic [tile_pkg::ADDR_WIDTH-1:0] wb_adr_i;
   logic [tile_pkg::DATA_WIDTH-1:0] wb_dat_i;
   logic [tile_pkg::SEL_WIDTH-1:0]  wb_sel_i;
   logic                            wb_ack_o;
   logic                            wb_err_o;
   logic [tile_pkg::DATA_WIDTH-1:0] wb_dat_o;
   logic [noc_pkg::FLIT_WIDTH-1:0]  noc_in_flit_i;
   logic                            noc_in_valid_i;
   logic                            noc_in_ready_o;
   logic [noc_pkg::FLIT_WIDTH-1:0]  noc_out_flit_o;
   logic                            noc_out_valid_o;
   logic                            noc_out_ready_i;
   logic                            irq_o;

   // Reference model state
   logic [tile_pkg::DATA_WIDTH-1:0] mem_model [N_INIT];
   logic [noc_pkg::FLIT_WIDTH-1:0]  exp_flits [$];
   logic [tile_pkg::DATA_WIDTH-1:0] exp_rx [$];
   int                              seed = 58;
   int                              ready_seed = 58;     // Back-pressure stream

   compute_tile #(
      .TILE_ID   (5'(TILE_ID)),
      .MEM_WORDS (MEM_WORDS),
      .RX_DEPTH  (RX_DEPTH)
   ) dut (.*);

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   task automatic fail_now(input string msg);
      $display("[FAIL] t=%0t %s", $time, msg);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_word(input logic [tile_pkg::DATA_WIDTH-1:0] got, exp,
                             input string what);
      if (got !== exp) begin
         fail_now($sformatf("%s: got %h, expected %h", what, got, exp));
      end
   endtask

   task automatic check_flit(input logic [noc_pkg::FLIT_WIDTH-1:0] got, exp);
      if (got !== exp) begin
         fail_now($sformatf("outgoing flit: got %h, expected %h", got, exp));
      end
   endtask

   task automatic check_resp(input logic got_err, exp_err,
                             input logic [tile_pkg::ADDR_WIDTH-1:0] adr);
      if (got_err !== exp_err) begin
         fail_now($sformatf("access to %h ended with %s where %s was expected", adr,
                            got_err ? "err" : "ack", exp_err ? "err" : "ack"));
      end
   endtask

   // One classic cycle, started and ended on a falling edge
   task automatic bus_access(input logic we, input logic [tile_pkg::ADDR_WIDTH-1:0] adr,
                             input logic [tile_pkg::DATA_WIDTH-1:0] wdat,
                             input logic [tile_pkg::SEL_WIDTH-1:0] sel,
                             output logic [tile_pkg::DATA_WIDTH-1:0] rdat,
                             output logic got_err);
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = adr;
      wb_dat_i = wdat;
      wb_sel_i = sel;
      @(negedge clk_i);
      while (!wb_ack_o && !wb_err_o) begin
         @(negedge clk_i);
      end
      got_err  = wb_err_o;
      rdat     = wb_dat_o;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      @(negedge clk_i);                            // Idle cycle between accesses
   endtask

   task automatic wb_write(input logic [tile_pkg::ADDR_WIDTH-1:0] adr,
                           input logic [tile_pkg::DATA_WIDTH-1:0] dat,
                           input logic [tile_pkg::SEL_WIDTH-1:0] sel);
      logic [tile_pkg::DATA_WIDTH-1:0] unused;
      logic                            err;
      bus_access(1'b1, adr, dat, sel, unused, err);
      check_resp(err, 1'b0, adr);
   endtask

   task automatic wb_read(input logic [tile_pkg::ADDR_WIDTH-1:0] adr,
                          output logic [tile_pkg::DATA_WIDTH-1:0] dat);
      logic err;
      bus_access(1'b0, adr, '0, 4'hF, dat, err);
      check_resp(err, 1'b0, adr);
   endtask

   task automatic wb_expect_err(input logic we, input logic [tile_pkg::ADDR_WIDTH-1:0] adr);
      logic [tile_pkg::DATA_WIDTH-1:0] unused;
      logic                            err;
      bus_access(we, adr, 32'hDEAD_BEEF, 4'hF, unused, err);
      check_resp(err, 1'b1, adr);
   endtask

   task automatic inject_flit(input logic [noc_pkg::FLIT_WIDTH-1:0] flit);
      noc_in_flit_i  = flit;
      noc_in_valid_i = 1'b1;
      while (!noc_in_ready_o) begin
         @(negedge clk_i);
      end
      @(negedge clk_i);                            // Taken on the rising edge before
      noc_in_valid_i = 1'b0;
   endtask

   task automatic check_count();
      logic [tile_pkg::DATA_WIDTH-1:0] rdata;
      wb_read(NA_SEND_ADR, rdata);
      check_word(rdata, exp_rx.size(), "receive count");
      if (irq_o !== (exp_rx.size() != 0)) begin
         fail_now("irq_o does not follow the receive count");
      end
   endtask

   task automatic pop_words(input int n);
      logic [tile_pkg::DATA_WIDTH-1:0] rdata;
      for (int i = 0; i < n; i++) begin
         wb_read(NA_RECV_ADR, rdata);
         check_word(rdata, exp_rx.pop_front(), "received word");
      end
   endtask

   // Random back-pressure and outgoing flit check
   always @(negedge clk_i) begin : out_monitor
      logic rdy;
      rdy = arst_n_i && ($unsigned($random(ready_seed)) % 4 != 0);
      noc_out_ready_i = rdy;
      if (noc_out_valid_o && rdy) begin
         if (exp_flits.size() == 0) begin
            fail_now("a flit left the tile that no write had sent");
         end
         check_flit(noc_out_flit_o, exp_flits.pop_front());
      end
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: the tests did not complete within %0d ns", TIMEOUT_NS);
      $display("Simulation finished: FAIL");
      $fatal(1, "watchdog expired");
   end

   initial begin
      logic [tile_pkg::DATA_WIDTH-1:0] rdata;
      logic [tile_pkg::DATA_WIDTH-1:0] wdata;
      logic [tile_pkg::SEL_WIDTH-1:0]  sel;
      noc_pkg::noc_hdr_u               hdr;
      int                              idx;
      int                              len;
      logic                            to_me;
      clk_i           = 1'b0;
      arst_n_i        = 1'b0;
      wb_cyc_i        = 1'b0;
      wb_stb_i        = 1'b0;
      wb_we_i         = 1'b0;
      wb_adr_i        = '0;
      wb_dat_i        = '0;
      wb_sel_i        = '0;
      noc_in_flit_i   = '0;
      noc_in_valid_i  = 1'b0;
      noc_out_ready_i = 1'b0;
      repeat (5) @(posedge clk_i);
      @(negedge clk_i);
      arst_n_i = 1'b1;
      @(negedge clk_i);
      if (wb_ack_o !== 1'b0 || wb_err_o !== 1'b0 || noc_out_valid_o !== 1'b0 ||
          irq_o !== 1'b0 || noc_in_ready_o !== 1'b1) begin
         fail_now("outputs are not in their reset state after reset");
      end

      for (int i = 0; i < N_INIT; i++) begin
         mem_model[i] = $random(seed);
         wb_write(32'(i * 4), mem_model[i], 4'hF);
      end
      for (int n = 0; n < N_MEM; n++) begin
         idx   = $unsigned($random(seed)) % N_INIT;
         wdata = $random(seed);
         sel   = 4'($random(seed));
         for (int b = 0; b < tile_pkg::SEL_WIDTH; b++) begin
            if (sel[b]) begin
               mem_model[idx][8*b +: 8] = wdata[8*b +: 8];
            end
         end
         wb_write(32'((idx * 4) + ((n % 2) * MEM_WORDS * 4)), wdata, sel);   // Odd n aliases
         idx = $unsigned($random(seed)) % N_INIT;
         wb_read(32'(idx * 4), rdata);
         check_word(rdata, mem_model[idx], "SRAM read");
      end

      for (int i = 0; i < 8; i++) begin
         wb_read({tile_pkg::ROM_MATCH, 23'($random(seed)), 3'(i), 2'b00}, rdata);
         check_word(rdata, tile_pkg::BOOT_ROM[i], "boot ROM read");
      end
      for (int i = 0; i < N_ERR; i++) begin
         wb_expect_err(1'(i % 2), {4'(8 + $unsigned($random(seed)) % 6), 28'($random(seed))});
      end

      for (int p = 0; p < N_TX; p++) begin
         len         = $unsigned($random(seed)) % (MAX_LEN + 1);
         hdr.raw     = $random(seed);
         hdr.hdr.len = 8'(len);
         exp_flits.push_back({1'b1, len == 0, hdr.raw});
         wb_write(NA_SEND_ADR, hdr.raw, 4'hF);
         for (int i = 0; i < len; i++) begin
            wdata = $random(seed);
            exp_flits.push_back({1'b0, i == len - 1, wdata});
            wb_write(NA_SEND_ADR, wdata, 4'hF);
         end
      end
      while (exp_flits.size() != 0) begin
         @(negedge clk_i);
      end

      wb_read(NA_RECV_ADR, rdata);
      check_word(rdata, '0, "pop from empty receive FIFO");
      for (int p = 0; p < N_RX; p++) begin
         if (exp_rx.size() > RX_DEPTH - (MAX_LEN + 1)) begin
            pop_words(exp_rx.size());              // Room for a full packet
         end
         to_me        = 1'($random(seed));
         len          = $unsigned($random(seed)) % (MAX_LEN + 1);
         hdr.raw      = $random(seed);
         hdr.hdr.dest = to_me ? 5'(TILE_ID) : 5'(TILE_ID + 1 + $unsigned($random(seed)) % 31);
         hdr.hdr.len  = 8'(len);
         if (to_me) begin
            exp_rx.push_back(hdr.raw);
         end
         inject_flit({1'b1, len == 0, hdr.raw});
         for (int i = 0; i < len; i++) begin
            wdata = $random(seed);
            if (to_me) begin
               exp_rx.push_back(wdata);
            end
            inject_flit({1'b0, i == len - 1, wdata});
         end
         check_count();
         pop_words($unsigned($random(seed)) % (exp_rx.size() + 1));
         check_count();
      end
      pop_words(exp_rx.size());
      check_count();

      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

// File: verilog.f
source/tile_pkg.sv
source/noc_pkg.sv
source/wb_bus_decode.sv
source/wb_sram_sp.sv
source/bootrom.sv
source/na_mp_simple.sv
source/compute_tile.sv
test/tb_compute_tile.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_compute_tile \
   -f verilog.f -o tb_compute_tile &&
./obj_dir/tb_compute_tile ||
{ echo "Build or simulation did not succeed"; exit 1; }
